/* PortalSlave.f */
hdl/PortalBusPkg.sv
hdl/PortalRegPkg.sv
hdl/BeatFifo.sv
hdl/BurstSplitter.sv
hdl/PortalControl.sv
hdl/UserQueue.sv
hdl/PortalTop.sv
tests/ClockGen.sv
tests/PortalChecker.sv
tests/PortalTb.sv

/* hdl/BeatFifo.sv */
`default_nettype none

module BeatFifo #(
  parameter int Width = 8
) (
  input  wire              CLK,
  input  wire              nRST,
  input  wire              enq,
  input  wire              deq,
  input  wire [Width-1:0]  dIn,
  output logic [Width-1:0] dOut,
  output logic             full,
  output logic             empty
);

  logic             valid;
  logic [Width-1:0] store;

  // Single slot, so no enq and deq in one cycle
  always_ff @(posedge CLK)
  begin
    if (!nRST)
      valid <= 1'b0;
    else if (enq && !valid)
      valid <= 1'b1;
    else if (deq && valid)
      valid <= 1'b0;
  end

  always_ff @(posedge CLK)
  begin
    if (enq && !valid)
      store <= dIn;
  end

  assign dOut  = store;
  assign full  = valid;
  assign empty = !valid;

endmodule

`default_nettype wire

/* hdl/BurstSplitter.sv */
`default_nettype none

module BurstSplitter (
  input  wire                              CLK,
  input  wire                              nRST,
  input  wire                              reqValid,
  input  wire PortalBusPkg::beatOffsetT    reqOffset,
  input  wire PortalBusPkg::busLenT        reqLen,
  input  wire                              beatRdy,
  output logic                             reqTake,
  output logic                             beatEna,
  output PortalBusPkg::beatOffsetT         beatOffset,
  output logic                             beatLast
);

  PortalRegPkg::burstStateT state;
  PortalBusPkg::beatOffsetT offsetReg;
  PortalBusPkg::beatCountT  countReg;
  PortalBusPkg::beatCountT  curCount;

  // First beat comes straight from the request
  always_comb
  begin
    if (state == PortalRegPkg::BurstFirst)
    begin
      beatOffset = reqOffset;
      curCount   = PortalBusPkg::beatCountT'(reqLen) + 5'd1;
    end
    else
    begin
      beatOffset = offsetReg;
      curCount   = countReg;
    end
  end

  assign beatEna  = reqValid && beatRdy;
  assign beatLast = curCount == 5'd1;
  assign reqTake  = beatEna && beatLast;  // Request leaves with its last beat

  always_ff @(posedge CLK)
  begin
    if (!nRST)
    begin
      state     <= PortalRegPkg::BurstFirst;
      offsetReg <= '0;
      countReg  <= '0;
    end
    else if (beatEna)
    begin
      offsetReg <= beatOffset + 5'd4;  // Wraps in 32 bytes
      countReg  <= curCount - 5'd1;
      if (beatLast)
        state <= PortalRegPkg::BurstFirst;
      else
        state <= PortalRegPkg::BurstNext;
    end
  end

endmodule

`default_nettype wire

/* hdl/PortalBusPkg.sv */
`default_nettype none

package PortalBusPkg;

  // Bus side fields
  typedef logic [31:0] busAddrT;
  typedef logic [5:0]  busIdT;
  typedef logic [3:0]  busLenT;   // Beats minus one
  typedef logic [31:0] busDataT;

  // Portal side fields
  typedef logic [4:0]  beatOffsetT;  // Byte offset inside 32 byte window
  typedef logic [4:0]  beatCountT;   // Up to 16 beats left

endpackage

`default_nettype wire

/* hdl/PortalControl.sv */
`default_nettype none

module PortalControl (
  input  wire                           CLK,
  input  wire                           nRST,
  // Read beats
  input  wire                           rdValid,
  input  wire PortalBusPkg::beatOffsetT rdOffset,
  input  wire                           rdCtrl,
  input  wire                           rdPortal,
  input  wire                           rdRoom,
  output logic                          rdTake,
  output PortalBusPkg::busDataT         rdData,
  // Write beats
  input  wire                           wrValid,
  input  wire PortalBusPkg::beatOffsetT wrOffset,
  input  wire                           wrCtrl,
  input  wire                           wrPortal,
  input  wire                           wrLast,
  input  wire                           wrRoom,
  input  wire PortalBusPkg::busDataT    wrData,
  output logic                          wrTake,
  // User queue
  input  wire PortalBusPkg::busDataT    head,
  input  wire                           notEmpty,
  input  wire                           notFull,
  output logic                          pushEna,
  output PortalBusPkg::busDataT         pushData,
  output logic                          popEna,
  output logic                          interrupt
);

  logic intEnable;

  assign rdTake = rdValid && rdRoom;

  // Read word
  always_comb
  begin
    rdData = '0;
    if (rdCtrl)
    begin
      case (rdOffset)
        PortalRegPkg::CtrlIntStatus:   rdData = {31'd0, notEmpty};
        PortalRegPkg::CtrlNumTiles:    rdData = PortalRegPkg::NumTiles;
        PortalRegPkg::CtrlQueueStatus: rdData = {31'd0, notEmpty};
        PortalRegPkg::CtrlPortalId:
          rdData = rdPortal ? PortalRegPkg::IndPortalId : PortalRegPkg::ReqPortalId;
        PortalRegPkg::CtrlNumPortals:  rdData = PortalRegPkg::NumPortals;
        default:                       rdData = '0;
      endcase
    end
    else
    begin
      case (rdOffset)
        PortalRegPkg::DataQueue:
          if (rdPortal && notEmpty)
            rdData = head;
        PortalRegPkg::DataNotFull:     rdData = {31'd0, notFull};
        default:                       rdData = '0;
      endcase
    end
  end

  // Only indication portal pops
  assign popEna = rdTake && !rdCtrl && rdPortal
                  && rdOffset == PortalRegPkg::DataQueue && notEmpty;

  // Last beat also needs a response slot
  assign wrTake = wrValid && (!wrLast || wrRoom);

  assign pushData = wrData;
  assign pushEna  = wrTake && !wrCtrl && !wrPortal
                    && wrOffset == PortalRegPkg::DataQueue && notFull;

  always_ff @(posedge CLK)
  begin
    if (!nRST)
    begin
      intEnable <= 1'b0;
      interrupt <= 1'b0;
    end
    else
    begin
      if (wrTake && wrCtrl && wrOffset == PortalRegPkg::CtrlIntEnable)
        intEnable <= wrData[0];
      interrupt <= intEnable && notEmpty;
    end
  end

endmodule

`default_nettype wire

/* hdl/PortalRegPkg.sv */
`default_nettype none

package PortalRegPkg;

  // Control region offsets
  localparam PortalBusPkg::beatOffsetT CtrlIntStatus   = 5'h00;
  localparam PortalBusPkg::beatOffsetT CtrlIntEnable   = 5'h04;
  localparam PortalBusPkg::beatOffsetT CtrlNumTiles    = 5'h08;
  localparam PortalBusPkg::beatOffsetT CtrlQueueStatus = 5'h0C;
  localparam PortalBusPkg::beatOffsetT CtrlPortalId    = 5'h10;
  localparam PortalBusPkg::beatOffsetT CtrlNumPortals  = 5'h14;

  // Data region offsets
  localparam PortalBusPkg::beatOffsetT DataQueue   = 5'h00;
  localparam PortalBusPkg::beatOffsetT DataNotFull = 5'h04;

  // Fixed read values
  localparam PortalBusPkg::busDataT ReqPortalId = 32'd5;
  localparam PortalBusPkg::busDataT IndPortalId = 32'd6;
  localparam PortalBusPkg::busDataT NumTiles    = 32'd1;
  localparam PortalBusPkg::busDataT NumPortals  = 32'd2;

  // Burst splitter phase
  typedef enum logic
  {
    BurstFirst,
    BurstNext
  } burstStateT;

endpackage

`default_nettype wire

/* hdl/PortalTop.sv */
`default_nettype none

module PortalTop #(
  parameter int UserDepth = 4
) (
  input  wire                        CLK,
  input  wire                        nRST,
  input  wire PortalBusPkg::busAddrT arAddr,
  input  wire PortalBusPkg::busIdT   arId,
  input  wire PortalBusPkg::busLenT  arLen,
  input  wire                        arEna,
  output logic                       arRdy,
  input  wire                        rRdy,
  output PortalBusPkg::busDataT      rData,
  output PortalBusPkg::busIdT        rId,
  output logic                       rLast,
  output logic                       rEna,
  input  wire PortalBusPkg::busAddrT awAddr,
  input  wire PortalBusPkg::busIdT   awId,
  input  wire PortalBusPkg::busLenT  awLen,
  input  wire                        awEna,
  output logic                       awRdy,
  input  wire PortalBusPkg::busDataT wData,
  input  wire                        wEna,
  output logic                       wRdy,
  input  wire                        bRdy,
  output PortalBusPkg::busIdT        bId,
  output logic                       bEna,
  output logic                       interrupt
);

  // Request entry is offset, len, id, ctrl, portal
  localparam int ReqW  = 17;
  // Beat entry is offset, id, last, ctrl, portal
  localparam int BeatW = 14;

  PortalBusPkg::beatOffsetT arOffQ, awOffQ, rdBeatOff, wrBeatOff, rdOffQ, wrOffQ;
  PortalBusPkg::busLenT     arLenQ, awLenQ;
  PortalBusPkg::busIdT      arIdQ, awIdQ, rdIdQ, wrIdQ;
  PortalBusPkg::busDataT    rdWord, wrWord, pushData, head;
  logic arCtrlQ, arPortalQ, arReqFull, arReqEmpty, arTake, rdBeatEna, rdBeatLast;
  logic rdLastQ, rdCtrlQ, rdPortalQ, readBeatFull, readBeatEmpty, readDataFull;
  logic readDataEmpty, rdTake;
  logic awCtrlQ, awPortalQ, awReqFull, awReqEmpty, awTake, wrBeatEna, wrBeatLast;
  logic wrLastQ, wrCtrlQ, wrPortalQ, writeBeatFull, writeBeatEmpty;
  logic writeDataFull, writeDataEmpty, writeDoneFull, writeDoneEmpty, wrTake;
  logic pushEna, popEna, notEmpty, notFull;

  // Read path
  BeatFifo #(.Width(ReqW)) arReq (
    .CLK(CLK), .nRST(nRST), .enq(arEna && arRdy), .deq(arTake),
    .dIn({arAddr[4:0], arLen, arId, arAddr[11:5] == 7'd0, arAddr[12]}),
    .dOut({arOffQ, arLenQ, arIdQ, arCtrlQ, arPortalQ}),
    .full(arReqFull), .empty(arReqEmpty));

  BurstSplitter readSplit (
    .CLK(CLK), .nRST(nRST), .reqValid(!arReqEmpty), .reqOffset(arOffQ),
    .reqLen(arLenQ), .beatRdy(!readBeatFull), .reqTake(arTake),
    .beatEna(rdBeatEna), .beatOffset(rdBeatOff), .beatLast(rdBeatLast));

  BeatFifo #(.Width(BeatW)) readBeat (
    .CLK(CLK), .nRST(nRST), .enq(rdBeatEna), .deq(rdTake),
    .dIn({rdBeatOff, arIdQ, rdBeatLast, arCtrlQ, arPortalQ}),
    .dOut({rdOffQ, rdIdQ, rdLastQ, rdCtrlQ, rdPortalQ}),
    .full(readBeatFull), .empty(readBeatEmpty));

  BeatFifo #(.Width(39)) readData (
    .CLK(CLK), .nRST(nRST), .enq(rdTake), .deq(rRdy),
    .dIn({rdWord, rdIdQ, rdLastQ}), .dOut({rData, rId, rLast}),
    .full(readDataFull), .empty(readDataEmpty));

  // Write path
  BeatFifo #(.Width(ReqW)) awReq (
    .CLK(CLK), .nRST(nRST), .enq(awEna && awRdy), .deq(awTake),
    .dIn({awAddr[4:0], awLen, awId, awAddr[11:5] == 7'd0, awAddr[12]}),
    .dOut({awOffQ, awLenQ, awIdQ, awCtrlQ, awPortalQ}),
    .full(awReqFull), .empty(awReqEmpty));

  BurstSplitter writeSplit (
    .CLK(CLK), .nRST(nRST), .reqValid(!awReqEmpty), .reqOffset(awOffQ),
    .reqLen(awLenQ), .beatRdy(!writeBeatFull), .reqTake(awTake),
    .beatEna(wrBeatEna), .beatOffset(wrBeatOff), .beatLast(wrBeatLast));

  BeatFifo #(.Width(BeatW)) writeBeat (
    .CLK(CLK), .nRST(nRST), .enq(wrBeatEna), .deq(wrTake),
    .dIn({wrBeatOff, awIdQ, wrBeatLast, awCtrlQ, awPortalQ}),
    .dOut({wrOffQ, wrIdQ, wrLastQ, wrCtrlQ, wrPortalQ}),
    .full(writeBeatFull), .empty(writeBeatEmpty));

  BeatFifo #(.Width(32)) writeData (
    .CLK(CLK), .nRST(nRST), .enq(wEna && wRdy), .deq(wrTake),
    .dIn(wData), .dOut(wrWord), .full(writeDataFull), .empty(writeDataEmpty));

  BeatFifo #(.Width(6)) writeDone (
    .CLK(CLK), .nRST(nRST), .enq(wrTake && wrLastQ), .deq(bRdy),
    .dIn(wrIdQ), .dOut(bId), .full(writeDoneFull), .empty(writeDoneEmpty));

  PortalControl control (
    .CLK(CLK), .nRST(nRST),
    .rdValid(!readBeatEmpty), .rdOffset(rdOffQ), .rdCtrl(rdCtrlQ), .rdPortal(rdPortalQ),
    .rdRoom(!readDataFull), .rdTake(rdTake), .rdData(rdWord),
    .wrValid(!writeBeatEmpty && !writeDataEmpty), .wrOffset(wrOffQ), .wrCtrl(wrCtrlQ),
    .wrPortal(wrPortalQ), .wrLast(wrLastQ), .wrRoom(!writeDoneFull), .wrData(wrWord),
    .wrTake(wrTake),
    .head(head), .notEmpty(notEmpty), .notFull(notFull),
    .pushEna(pushEna), .pushData(pushData), .popEna(popEna),
    .interrupt(interrupt));

  UserQueue #(.UserDepth(UserDepth)) user (
    .CLK(CLK), .nRST(nRST), .pushEna(pushEna), .pushData(pushData), .popEna(popEna),
    .head(head), .notEmpty(notEmpty), .notFull(notFull));

  assign arRdy = !arReqFull;
  assign awRdy = !awReqFull;
  assign wRdy  = !writeDataFull;
  assign rEna  = !readDataEmpty;
  assign bEna  = !writeDoneEmpty;

endmodule

`default_nettype wire

/* hdl/UserQueue.sv */
`default_nettype none

module UserQueue #(
  parameter int UserDepth = 4
) (
  input  wire                        CLK,
  input  wire                        nRST,
  input  wire                        pushEna,
  input  wire PortalBusPkg::busDataT pushData,
  input  wire                        popEna,
  output PortalBusPkg::busDataT      head,
  output logic                       notEmpty,
  output logic                       notFull
);

  localparam int PtrW = (UserDepth > 1) ? $clog2(UserDepth) : 1;
  localparam int CntW = $clog2(UserDepth + 1);

  PortalBusPkg::busDataT mem [UserDepth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [CntW-1:0] count;
  logic            doPush;
  logic            doPop;

  assign notEmpty = count != '0;
  assign notFull  = count != CntW'(UserDepth);
  assign doPush   = pushEna && notFull;   // Full queue drops the word
  assign doPop    = popEna && notEmpty;
  assign head     = mem[rdPtr];

  always_ff @(posedge CLK)
  begin
    if (doPush)
      mem[wrPtr] <= pushData;
  end

  always_ff @(posedge CLK)
  begin
    if (!nRST)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == PtrW'(UserDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PtrW'(UserDepth - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tests/ClockGen.sv */
`default_nettype none

module ClockGen #(
  parameter int Period      = 100,
  parameter int ResetCycles = 5
) (
  output logic CLK,
  output logic nRST
);

  initial
  begin
    CLK  = 1'b0;
    nRST = 1'b0;
    repeat (ResetCycles) @(posedge CLK);
    nRST <= 1'b1;  // Released on a rising edge
  end

  always #(Period / 2) CLK = ~CLK;

endmodule

`default_nettype wire

/* tests/PortalChecker.sv */
`default_nettype none

module PortalChecker (
  input wire                        CLK,
  input wire                        nRST,
  input wire                        rEna,
  input wire                        rRdy,
  input wire PortalBusPkg::busDataT rData,
  input wire PortalBusPkg::busIdT   rId,
  input wire                        rLast,
  input wire                        bEna,
  input wire                        bRdy,
  input wire PortalBusPkg::busIdT   bId,
  input wire                        interrupt
);

  logic [38:0]         expRead[$];  // Data, id, last
  PortalBusPkg::busIdT expResp[$];
  logic [38:0]         nextRead;
  string               testName = "reset";
  int                  passCount = 0;
  int                  failCount = 0;

  task automatic setTest(input string name);
    testName = name;
  endtask

  task automatic expectRead(input PortalBusPkg::busDataT data, input PortalBusPkg::busIdT id,
                            input logic last);
    expRead.push_back({data, id, last});
  endtask

  task automatic expectResp(input PortalBusPkg::busIdT id);
    expResp.push_back(id);
  endtask

  task automatic compareField(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual === expected)
      passCount++;
    else
    begin
      failCount++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", testName, field, expected, actual);
    end
  endtask

  task automatic checkIrq(input logic expected);
    compareField("interrupt", expected, interrupt);
  endtask

  task automatic reportLeftovers();
    if (expRead.size() != 0 || expResp.size() != 0)
    begin
      failCount++;
      $display("Test %s ended with %0d read beats and %0d write responses never seen",
               testName, expRead.size(), expResp.size());
      expRead.delete();
      expResp.delete();
    end
  endtask

  // Seen here, the transfer completes on the next rising edge
  always @(negedge CLK)
  begin
    if (nRST === 1'b1 && rEna === 1'b1 && rRdy === 1'b1)
    begin
      if (expRead.size() == 0)
      begin
        failCount++;
        $display("Test %s got a read beat that no request asked for", testName);
      end
      else
      begin
        nextRead = expRead.pop_front();
        compareField("rData", nextRead[38:7], rData);
        compareField("rId", nextRead[6:1], rId);
        compareField("rLast", nextRead[0], rLast);
      end
    end
    if (nRST === 1'b1 && bEna === 1'b1 && bRdy === 1'b1)
    begin
      if (expResp.size() == 0)
      begin
        failCount++;
        $display("Test %s got a write response that no request asked for", testName);
      end
      else
        compareField("bId", expResp.pop_front(), bId);
    end
  end

endmodule

`default_nettype wire

/* tests/PortalTb.sv */
`default_nettype none

module PortalTb;

  localparam int ClockPeriod = 100;
  localparam int UserDepth   = 4;
  localparam int CtrlBursts  = 12;
  localparam int QueueOps    = 20;
  localparam int IrqOps      = 12;
  localparam int WriteBursts = 8;
  // Worst case beats over both passes, write burst plus read burst each
  localparam int PlannedBeats =
    2 * (CtrlBursts * 16 + QueueOps * 2 + IrqOps * 2 + WriteBursts * 33);

  logic CLK, nRST;
  PortalBusPkg::busAddrT arAddr, awAddr;
  PortalBusPkg::busIdT   arId, awId, rId, bId;
  PortalBusPkg::busLenT  arLen, awLen;
  PortalBusPkg::busDataT rData, wData;
  logic arEna, arRdy, rRdy, rLast, rEna;
  logic awEna, awRdy, wEna, wRdy, bRdy, bEna, interrupt;

  PortalBusPkg::busDataT modelQ[$];  // Mirrors the user queue
  logic                  irqEnable;
  logic                  backPressure;
  int                    failsBefore;

  ClockGen #(.Period(ClockPeriod)) clocks (.CLK(CLK), .nRST(nRST));

  PortalTop #(.UserDepth(UserDepth)) u_dut (
    .CLK(CLK), .nRST(nRST),
    .arAddr(arAddr), .arId(arId), .arLen(arLen), .arEna(arEna), .arRdy(arRdy),
    .rRdy(rRdy), .rData(rData), .rId(rId), .rLast(rLast), .rEna(rEna),
    .awAddr(awAddr), .awId(awId), .awLen(awLen), .awEna(awEna), .awRdy(awRdy),
    .wData(wData), .wEna(wEna), .wRdy(wRdy),
    .bRdy(bRdy), .bId(bId), .bEna(bEna), .interrupt(interrupt));

  PortalChecker chk (
    .CLK(CLK), .nRST(nRST), .rEna(rEna), .rRdy(rRdy), .rData(rData), .rId(rId),
    .rLast(rLast), .bEna(bEna), .bRdy(bRdy), .bId(bId), .interrupt(interrupt));

  // Bits 11 to 5 zero for control, bit 12 picks the portal
  function automatic PortalBusPkg::busAddrT makeAddr(input logic ctrl, input logic portal,
                                                     input PortalBusPkg::beatOffsetT off);
    logic [6:0] region;
    region = ctrl ? 7'd0 : 7'($urandom_range(1, 127));
    return {19'($urandom), portal, region, off};
  endfunction

  task automatic modelRead(input logic ctrl, input logic portal,
                           input PortalBusPkg::beatOffsetT off,
                           output PortalBusPkg::busDataT value);
    value = 32'd0;
    if (ctrl)
    begin
      case (off)
        5'h00, 5'h0C: value = (modelQ.size() != 0) ? 32'd1 : 32'd0;
        5'h08:        value = 32'd1;
        5'h10:        value = portal ? 32'd6 : 32'd5;
        5'h14:        value = 32'd2;
        default:      value = 32'd0;
      endcase
    end
    else if (off == 5'h00 && portal && modelQ.size() != 0)
      value = modelQ.pop_front();
    else if (off == 5'h04)
      value = (modelQ.size() < UserDepth) ? 32'd1 : 32'd0;
  endtask

  // Entered on a rising edge, returns on the falling edge after the last transfer
  task automatic finishTransfer(input logic isRead);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      if (isRead)
        rRdy <= backPressure ? 1'($urandom_range(0, 1)) : 1'b1;
      else
        bRdy <= backPressure ? 1'($urandom_range(0, 1)) : 1'b1;
      @(negedge CLK);
      if (isRead)
        done = rEna === 1'b1 && rRdy === 1'b1 && rLast === 1'b1;
      else
        done = bEna === 1'b1 && bRdy === 1'b1;
      @(posedge CLK);
    end
    @(negedge CLK);
    chk.checkIrq(irqEnable && modelQ.size() != 0);
  endtask

  task automatic runRead(input logic ctrl, input logic portal,
                         input PortalBusPkg::beatOffsetT off, input PortalBusPkg::busLenT len);
    PortalBusPkg::busIdT      id;
    PortalBusPkg::busDataT    value;
    PortalBusPkg::beatOffsetT beatOff;
    int                       i;
    id      = 6'($urandom);
    beatOff = off;
    for (i = 0; i <= int'(len); i++)
    begin
      modelRead(ctrl, portal, beatOff, value);
      chk.expectRead(value, id, i == int'(len));
      beatOff = beatOff + 5'd4;  // Wraps inside 32 bytes
    end
    @(posedge CLK);
    arAddr <= makeAddr(ctrl, portal, off);
    arId   <= id;
    arLen  <= len;
    arEna  <= 1'b1;
    @(negedge CLK);
    while (arRdy !== 1'b1)
      @(negedge CLK);
    @(posedge CLK);
    arEna <= 1'b0;
    finishTransfer(1'b1);
  endtask

  task automatic runWrite(input logic ctrl, input logic portal,
                          input PortalBusPkg::beatOffsetT off, input PortalBusPkg::busLenT len);
    PortalBusPkg::busIdT      id;
    PortalBusPkg::busDataT    data;
    PortalBusPkg::beatOffsetT beatOff;
    int                       i;
    id = 6'($urandom);
    chk.expectResp(id);
    @(posedge CLK);
    awAddr <= makeAddr(ctrl, portal, off);
    awId   <= id;
    awLen  <= len;
    awEna  <= 1'b1;
    @(negedge CLK);
    while (awRdy !== 1'b1)
      @(negedge CLK);
    @(posedge CLK);
    awEna   <= 1'b0;
    beatOff = off;
    for (i = 0; i <= int'(len); i++)
    begin
      data = $urandom;
      if (ctrl && beatOff == 5'h04)
        irqEnable = data[0];
      else if (!ctrl && !portal && beatOff == 5'h00 && modelQ.size() < UserDepth)
        modelQ.push_back(data);  // Full queue drops it
      beatOff = beatOff + 5'd4;
      wData <= data;
      wEna  <= 1'b1;
      @(negedge CLK);
      while (wRdy !== 1'b1)
        @(negedge CLK);
      @(posedge CLK);
    end
    wEna <= 1'b0;
    finishTransfer(1'b0);
  endtask

  task automatic startTest(input string name);
    chk.setTest(backPressure ? $sformatf("%s with back-pressure", name) : name);
    failsBefore = chk.failCount;
  endtask

  task automatic endTest();
    chk.reportLeftovers();
    $display("Test %s finished, %0d failures", chk.testName, chk.failCount - failsBefore);
  endtask

  task automatic runSuite(input logic pressure);
    int n;
    backPressure = pressure;
    startTest("controlReads");
    for (n = 0; n < CtrlBursts; n++)
      runRead(1'b1, n[0], {3'($urandom), 2'b00}, (n % 3 == 0) ? 4'd0 : 4'($urandom));
    endTest();
    startTest("queueLoopback");
    for (n = 0; n < QueueOps; n++)
    begin
      // Overfill first, drain past empty last
      if (n < 6)
        runWrite(1'b0, 1'b0, 5'h00, 4'd0);
      else if (n >= QueueOps - 6)
        runRead(1'b0, 1'b1, 5'h00, 4'd0);
      else
        case ($urandom_range(0, 2))
          0:       runWrite(1'b0, 1'b0, 5'h00, 4'd0);
          1:       runRead(1'b0, 1'b1, 5'h00, 4'd0);
          default: runRead(1'b0, 1'b1, 5'h04, 4'd0);
        endcase
    end
    endTest();
    startTest("interrupt");
    for (n = 0; n < IrqOps; n++)
      case ($urandom_range(0, 2))
        0:       runWrite(1'b1, 1'($urandom), 5'h04, 4'd0);
        1:       runWrite(1'b0, 1'b0, 5'h00, 4'd0);
        default: runRead(1'b0, 1'b1, 5'h00, 4'd0);
      endcase
    endTest();
    startTest("burstIds");
    for (n = 0; n < WriteBursts; n++)
    begin
      runWrite(1'($urandom), 1'($urandom), {3'($urandom), 2'b00}, 4'($urandom));
      runRead(1'b0, 1'($urandom), {3'($urandom), 2'b00}, 4'($urandom));
    end
    endTest();
  endtask

  initial
  begin
    void'($urandom(32'h4cb));
    irqEnable    = 1'b0;
    backPressure = 1'b0;
    failsBefore  = 0;
    arAddr <= '0;
    arId   <= '0;
    arLen  <= '0;
    arEna  <= 1'b0;
    rRdy   <= 1'b0;
    awAddr <= '0;
    awId   <= '0;
    awLen  <= '0;
    awEna  <= 1'b0;
    wData  <= '0;
    wEna   <= 1'b0;
    bRdy   <= 1'b0;
    @(posedge CLK);
    while (nRST !== 1'b1)
      @(posedge CLK);
    runSuite(1'b0);
    runSuite(1'b1);
    $display("Checks passed %0d, failed %0d", chk.passCount, chk.failCount);
    if (chk.failCount == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    #(PlannedBeats * 200 * ClockPeriod);
    $display("Timeout after %0d cycles, test %s never finished",
             PlannedBeats * 200, chk.testName);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
